// File: hdl/soc_pkg.sv
// system bus package
// widths of the master bus signals and the address slot codes
// that the bus mux decodes from the top address bits
// slots not listed here belong to the data RAM

`default_nettype none

package soc_pkg;

   // byte address on the master bus
   typedef logic [31:0] wb_adr_t;

   // one data word, used for both write and read data
   typedef logic [31:0] wb_dat_t;

   // one select bit per byte lane of a data word
   typedef logic [3:0] wb_sel_t;

   // top three address bits, which pick the slave
   typedef logic [2:0] slot_t;

   // peripheral slots
   localparam slot_t SLOT_GPIO  = 3'b100;
   localparam slot_t SLOT_TIMER = 3'b101;

   // no slave here, reads give zero and writes are dropped
   localparam slot_t SLOT_UNMAPPED = 3'b110;

   // RAM answers on 000 to 011 and on 111

endpackage

`default_nettype wire

// File: hdl/soc_bus_mux.sv
// system bus mux
// decodes the slot of the master address into one slave strobe,
// selects the read data of the addressed slave and produces the
// registered single-cycle acknowledge for the master
// the unmapped slot reads as zero and gets no strobe

`default_nettype none

module soc_bus_mux (
   input  wire                   i_clk,
   input  wire                   i_rst,

   // master side
   input  wire soc_pkg::wb_adr_t i_wb_adr,
   input  wire                   i_wb_cyc,
   output soc_pkg::wb_dat_t      o_wb_rdt,
   output logic                  o_wb_ack,

   // slave strobes
   output logic                  o_ram_cyc,
   output logic                  o_gpio_cyc,
   output logic                  o_timer_cyc,

   // slave read data
   input  wire soc_pkg::wb_dat_t i_ram_rdt,
   input  wire soc_pkg::wb_dat_t i_gpio_rdt,
   input  wire soc_pkg::wb_dat_t i_timer_rdt
);

   soc_pkg::slot_t slot;

   logic hit_gpio;
   logic hit_timer;
   logic hit_unmapped;
   logic hit_ram;

   // slot sits in the top bits of the byte address
   assign slot = i_wb_adr[$bits(soc_pkg::wb_adr_t)-1 -: $bits(soc_pkg::slot_t)];

   assign hit_gpio     = (slot == soc_pkg::SLOT_GPIO);
   assign hit_timer    = (slot == soc_pkg::SLOT_TIMER);
   assign hit_unmapped = (slot == soc_pkg::SLOT_UNMAPPED);

   // everything else is RAM, which gives the mirror at 111
   assign hit_ram = ~(hit_gpio | hit_timer | hit_unmapped);

   // at most one strobe is high at a time
   assign o_ram_cyc   = i_wb_cyc & hit_ram;
   assign o_gpio_cyc  = i_wb_cyc & hit_gpio;
   assign o_timer_cyc = i_wb_cyc & hit_timer;

   // read data follows the held address
   // RAM data is registered and valid in the ack cycle
   always_comb begin
      case (slot)
         soc_pkg::SLOT_GPIO: begin
            o_wb_rdt = i_gpio_rdt;
         end
         soc_pkg::SLOT_TIMER: begin
            o_wb_rdt = i_timer_rdt;
         end
         soc_pkg::SLOT_UNMAPPED: begin
            o_wb_rdt = '0;
         end
         default: begin
            o_wb_rdt = i_ram_rdt;
         end
      endcase
   end

   // ack one cycle after the request, then cleared for one cycle
   // so a held cyc gives a toggling ack
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb_ack <= 1'b0;
      end else begin
         o_wb_ack <= i_wb_cyc & ~o_wb_ack;
      end
   end

endmodule

`default_nettype wire

// File: hdl/soc_ram.sv
// data RAM
// word-organised memory behind the system bus with byte-lane writes
// the word index is taken from the address bits above the byte
// offset and cut to the depth, so higher addresses alias
// read data is registered on every strobed cycle

`default_nettype none

module soc_ram #(
   parameter int RAM_DEPTH = 256
) (
   input  wire                   i_clk,
   input  wire soc_pkg::wb_adr_t i_adr,
   input  wire soc_pkg::wb_dat_t i_dat,
   input  wire soc_pkg::wb_sel_t i_sel,
   input  wire                   i_we,
   input  wire                   i_cyc,
   output soc_pkg::wb_dat_t      o_rdt
);

   // word address width, RAM_DEPTH is a power of two
   localparam int AW = $clog2(RAM_DEPTH);

   // bits of byte offset inside one word
   localparam int OFS = $clog2($bits(soc_pkg::wb_sel_t));

   soc_pkg::wb_dat_t mem [RAM_DEPTH];

   logic [AW-1:0] word_adr;

   assign word_adr = i_adr[OFS +: AW];

   // write selected lanes only
   always_ff @(posedge i_clk) begin
      if (i_cyc & i_we) begin
         for (int lane = 0; lane < $bits(soc_pkg::wb_sel_t); lane++) begin
            if (i_sel[lane]) begin
               mem[word_adr][8*lane +: 8] <= i_dat[8*lane +: 8];
            end
         end
      end
   end

   // read on every strobe, old content shows during a write
   always_ff @(posedge i_clk) begin
      if (i_cyc) begin
         o_rdt <= mem[word_adr];
      end
   end

endmodule

`default_nettype wire

// File: hdl/soc_gpio.sv
// GPIO port
// single output bit, loaded from data bit 0 on a strobed write
// and read back zero-extended to a full bus word

`default_nettype none

module soc_gpio (
   input  wire              i_clk,
   input  wire              i_rst,
   input  wire              i_dat,
   input  wire              i_we,
   input  wire              i_cyc,
   output soc_pkg::wb_dat_t o_rdt,
   output logic             o_gpio
);

   // a repeated write in the ack cycle stores the same bit again
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_gpio <= 1'b0;
      end else if (i_cyc & i_we) begin
         o_gpio <= i_dat;
      end
   end

   // upper bits read as zero
   assign o_rdt = soc_pkg::wb_dat_t'(o_gpio);

endmodule

`default_nettype wire

// File: hdl/soc_timer.sv
// machine timer
// free-running 32-bit time counter with a compare register
// the interrupt is a registered level, high while the count is
// at or above the compare value
// reads return the count, writes load the compare register

`default_nettype none

module soc_timer (
   input  wire                   i_clk,
   input  wire                   i_rst,
   input  wire soc_pkg::wb_dat_t i_dat,
   input  wire                   i_we,
   input  wire                   i_cyc,
   output soc_pkg::wb_dat_t      o_rdt,
   output logic                  o_irq
);

   soc_pkg::wb_dat_t mtime;
   soc_pkg::wb_dat_t mtimecmp;

   // counts every clock, wraps at the top
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         mtime <= '0;
      end else begin
         mtime <= mtime + 32'd1;
      end
   end

   // all ones after reset keeps the interrupt quiet
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         mtimecmp <= '1;
      end else if (i_cyc & i_we) begin
         mtimecmp <= i_dat;
      end
   end

   // unsigned compare
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_irq <= 1'b0;
      end else begin
         o_irq <= (mtime >= mtimecmp);
      end
   end

   assign o_rdt = mtime;

endmodule

`default_nettype wire

// File: hdl/soc_top.sv
// system bus top level
// one master bus port decoded into data RAM, a one-bit GPIO and
// a machine timer with a compare interrupt
// address, data, sel and we go straight to every slave, the mux
// adds the strobes, the read data select and the acknowledge

`default_nettype none

module soc_top #(
   parameter int RAM_DEPTH = 256
) (
   input  wire                   i_clk,
   input  wire                   i_rst,

   // master bus
   input  wire soc_pkg::wb_adr_t i_wb_adr,
   input  wire soc_pkg::wb_dat_t i_wb_dat,
   input  wire soc_pkg::wb_sel_t i_wb_sel,
   input  wire                   i_wb_we,
   input  wire                   i_wb_cyc,
   output soc_pkg::wb_dat_t      o_wb_rdt,
   output logic                  o_wb_ack,

   // peripheral pins
   output logic                  o_gpio,
   output logic                  o_timer_irq
);

   // strobes from the mux
   logic ram_cyc;
   logic gpio_cyc;
   logic timer_cyc;

   // read data back to the mux
   soc_pkg::wb_dat_t ram_rdt;
   soc_pkg::wb_dat_t gpio_rdt;
   soc_pkg::wb_dat_t timer_rdt;

   soc_bus_mux u_mux (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_wb_adr    (i_wb_adr),
      .i_wb_cyc    (i_wb_cyc),
      .o_wb_rdt    (o_wb_rdt),
      .o_wb_ack    (o_wb_ack),
      .o_ram_cyc   (ram_cyc),
      .o_gpio_cyc  (gpio_cyc),
      .o_timer_cyc (timer_cyc),
      .i_ram_rdt   (ram_rdt),
      .i_gpio_rdt  (gpio_rdt),
      .i_timer_rdt (timer_rdt)
   );

   // memory side
   soc_ram #(
      .RAM_DEPTH (RAM_DEPTH)
   ) u_ram (
      .i_clk (i_clk),
      .i_adr (i_wb_adr),
      .i_dat (i_wb_dat),
      .i_sel (i_wb_sel),
      .i_we  (i_wb_we),
      .i_cyc (ram_cyc),
      .o_rdt (ram_rdt)
   );

   // peripheral block
   // only data bit 0 reaches the GPIO
   soc_gpio u_gpio (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_dat  (i_wb_dat[0]),
      .i_we   (i_wb_we),
      .i_cyc  (gpio_cyc),
      .o_rdt  (gpio_rdt),
      .o_gpio (o_gpio)
   );

   soc_timer u_timer (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_dat (i_wb_dat),
      .i_we  (i_wb_we),
      .i_cyc (timer_cyc),
      .o_rdt (timer_rdt),
      .o_irq (o_timer_irq)
   );

endmodule

`default_nettype wire

// File: dv/soc_tb.sv
// system bus testbench
// acts as the bus master of soc_top and runs directed tests for
// reset state, RAM byte lanes, address decode and mirroring, GPIO
// and the machine timer with its compare interrupt

`default_nettype none

module soc_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 10;
   localparam int ACK_LIMIT  = 8;
   localparam int IRQ_LIMIT  = 200;

   // about 60 bus cycles of 3 clocks plus the interrupt wait,
   // with a wide margin on top
   localparam int TEST_CYCLES = 2000;

   localparam logic [31:0] LFSR_SEED = 32'h1300fcc8;

   logic             clk;
   logic             rst;
   soc_pkg::wb_adr_t wb_adr;
   soc_pkg::wb_dat_t wb_dat;
   soc_pkg::wb_sel_t wb_sel;
   logic             wb_we;
   logic             wb_cyc;
   soc_pkg::wb_dat_t wb_rdt;
   logic             wb_ack;
   logic             gpio;
   logic             timer_irq;

   int          error_count;
   int          test_count;
   int          depth;
   logic [31:0] lfsr_state;

   // written RAM words, keyed by word index
   logic [31:0] ram_model [int];

   soc_top dut (
      .i_clk       (clk),
      .i_rst       (rst),
      .i_wb_adr    (wb_adr),
      .i_wb_dat    (wb_dat),
      .i_wb_sel    (wb_sel),
      .i_wb_we     (wb_we),
      .i_wb_cyc    (wb_cyc),
      .o_wb_rdt    (wb_rdt),
      .o_wb_ack    (wb_ack),
      .o_gpio      (gpio),
      .o_timer_irq (timer_irq)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TEST_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the tests completed");
      $display("Test FAILED");
      $finish;
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one LFSR step per bit taken
   task automatic rand_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[30:0], lfsr_state[0]};
      end
   endtask

   function automatic soc_pkg::wb_adr_t make_adr(input soc_pkg::slot_t slot, input int word);
      return {slot, 29'(word << 2)};
   endfunction

   task automatic wait_ack();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (wb_ack !== 1'b1 && cycles < ACK_LIMIT) begin
         cycles++;
         @(negedge clk);
      end
      if (wb_ack !== 1'b1) begin
         $display("no acknowledge within %0d cycles at address %h", ACK_LIMIT, wb_adr);
         error_count++;
      end
   endtask

   // cyc drops in the cycle after ack, and ack must fall with it
   task automatic release_bus();
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_we  <= 1'b0;
      @(negedge clk);
      if (wb_ack !== 1'b0) begin
         $display("[FAIL] o_wb_ack expected %h got %h", 1'b0, wb_ack);
         error_count++;
      end
   endtask

   task automatic bus_write(input soc_pkg::wb_adr_t adr, input soc_pkg::wb_dat_t dat,
                            input soc_pkg::wb_sel_t sel);
      @(posedge clk);
      wb_adr <= adr;
      wb_dat <= dat;
      wb_sel <= sel;
      wb_we  <= 1'b1;
      wb_cyc <= 1'b1;
      wait_ack();
      release_bus();
   endtask

   task automatic bus_read(input soc_pkg::wb_adr_t adr, output soc_pkg::wb_dat_t dat);
      @(posedge clk);
      wb_adr <= adr;
      wb_dat <= '0;
      wb_sel <= '1;
      wb_we  <= 1'b0;
      wb_cyc <= 1'b1;
      wait_ack();
      dat = wb_rdt;
      release_bus();
   endtask

   task automatic read_expect(input soc_pkg::wb_adr_t adr, input logic [31:0] expected);
      logic [31:0] got;
      bus_read(adr, got);
      if (got !== expected) begin
         $display("[FAIL] o_wb_rdt at %h expected %h got %h", adr, expected, got);
         error_count++;
      end
   endtask

   task automatic test_reset_state();
      logic [31:0] got;
      test_count++;
      if (wb_ack !== 1'b0 || gpio !== 1'b0 || timer_irq !== 1'b0) begin
         $display("[FAIL] o_wb_ack/o_gpio/o_timer_irq expected %h/%h/%h got %h/%h/%h",
                  1'b0, 1'b0, 1'b0, wb_ack, gpio, timer_irq);
         error_count++;
      end
      bus_read(make_adr(soc_pkg::SLOT_UNMAPPED, 5), got);
      if (got !== 32'h0) begin
         $display("[FAIL] o_wb_rdt unmapped expected %h got %h", 32'h0, got);
         error_count++;
      end
      // a dropped write must not reach the RAM word with the same low bits
      bus_write(make_adr(3'b000, 5), 32'h5a5a_0ff0, 4'hf);
      ram_model[5] = 32'h5a5a_0ff0;
      bus_write(make_adr(soc_pkg::SLOT_UNMAPPED, 5), 32'hdead_beef, 4'hf);
      read_expect(make_adr(soc_pkg::SLOT_UNMAPPED, 5), 32'h0);
      read_expect(make_adr(3'b000, 5), ram_model[5]);
   endtask

   task automatic test_ram_lanes();
      logic [31:0] data;
      logic [31:0] pick;
      logic [31:0] expected;
      soc_pkg::wb_sel_t sel;
      int word;
      test_count++;
      for (int i = 0; i < 8; i++) begin
         rand_bits(32, data);
         word = i * 3 + 1;
         bus_write(make_adr(3'b000, word), data, 4'hf);
         ram_model[word] = data;
      end
      for (int i = 0; i < 8; i++) begin
         word = i * 3 + 1;
         read_expect(make_adr(3'b000, word), ram_model[word]);
      end
      // partial writes, old and new bytes merged per lane
      for (int i = 0; i < 12; i++) begin
         rand_bits(3, pick);
         word = int'(pick[2:0]) * 3 + 1;
         rand_bits(4, pick);
         sel = pick[3:0];
         rand_bits(32, data);
         bus_write(make_adr(3'b000, word), data, sel);
         expected = ram_model[word];
         for (int lane = 0; lane < 4; lane++) begin
            if (sel[lane]) begin
               expected[8*lane +: 8] = data[8*lane +: 8];
            end
         end
         ram_model[word] = expected;
         read_expect(make_adr(3'b000, word), expected);
      end
   endtask

   task automatic test_decode_mirror();
      logic [31:0] data;
      test_count++;
      rand_bits(32, data);
      bus_write(make_adr(3'b000, 40), data, 4'hf);
      ram_model[40] = data;
      read_expect(make_adr(3'b001, 40), data);
      read_expect(make_adr(3'b011, 40), data);
      read_expect(make_adr(3'b111, 40), data);
      // one full depth further wraps onto the same word
      read_expect(make_adr(3'b000, 40 + depth), data);
   endtask

   task automatic test_gpio();
      test_count++;
      bus_write(make_adr(soc_pkg::SLOT_GPIO, 0), 32'h0000_0001, 4'hf);
      if (gpio !== 1'b1) begin
         $display("[FAIL] o_gpio expected %h got %h", 1'b1, gpio);
         error_count++;
      end
      read_expect(make_adr(soc_pkg::SLOT_GPIO, 0), 32'h1);
      bus_write(make_adr(soc_pkg::SLOT_GPIO, 0), 32'hffff_fffe, 4'hf);
      if (gpio !== 1'b0) begin
         $display("[FAIL] o_gpio expected %h got %h", 1'b0, gpio);
         error_count++;
      end
      read_expect(make_adr(soc_pkg::SLOT_GPIO, 0), 32'h0);
   endtask

   task automatic test_timer();
      logic [31:0] t1;
      logic [31:0] t2;
      logic [31:0] cmp;
      logic [31:0] got;
      int cycles;
      test_count++;
      bus_read(make_adr(soc_pkg::SLOT_TIMER, 0), t1);
      bus_read(make_adr(soc_pkg::SLOT_TIMER, 0), t2);
      if (!(t2 > t1)) begin
         $display("[FAIL] o_wb_rdt timer count %h not above earlier %h", t2, t1);
         error_count++;
      end
      cmp = t2 + 32'd100;
      bus_write(make_adr(soc_pkg::SLOT_TIMER, 0), cmp, 4'hf);
      if (timer_irq !== 1'b0) begin
         $display("[FAIL] o_timer_irq expected %h got %h", 1'b0, timer_irq);
         error_count++;
      end
      cycles = 0;
      while (timer_irq !== 1'b1 && cycles < IRQ_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (timer_irq !== 1'b1) begin
         $display("timer interrupt did not rise within %0d cycles", IRQ_LIMIT);
         error_count++;
      end else begin
         bus_read(make_adr(soc_pkg::SLOT_TIMER, 0), got);
         if (got < cmp) begin
            $display("[FAIL] o_wb_rdt timer count %h below compare %h", got, cmp);
            error_count++;
         end
      end
      bus_write(make_adr(soc_pkg::SLOT_TIMER, 0), 32'hffff_ffff, 4'hf);
      if (timer_irq !== 1'b0) begin
         $display("[FAIL] o_timer_irq expected %h got %h", 1'b0, timer_irq);
         error_count++;
      end
   endtask

   initial begin
      rst         = 1'b1;
      wb_adr      = '0;
      wb_dat      = '0;
      wb_sel      = '0;
      wb_we       = 1'b0;
      wb_cyc      = 1'b0;
      error_count = 0;
      test_count  = 0;
      lfsr_state  = LFSR_SEED;
      depth       = dut.RAM_DEPTH;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      test_reset_state();
      test_ram_lanes();
      test_decode_mirror();
      test_gpio();
      test_timer();
      $display("%0d tests run, %0d errors", test_count, error_count);
      if (error_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
hdl/soc_pkg.sv
hdl/soc_bus_mux.sv
hdl/soc_ram.sv
hdl/soc_gpio.sv
hdl/soc_timer.sv
hdl/soc_top.sv
dv/soc_tb.sv

// File: Makefile
# Verilator build and run of the system bus testbench

VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= Test OK

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
